//--- Bender.yml
package:
  name: mcu_ao

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mcu_ao_pkg.sv
      - rtl/ao_bus_demux.sv
      - rtl/gpio_bank.sv
      - rtl/power_seq.sv
      - rtl/power_ctrl.sv
      - rtl/mcu_ao_top.sv
  - target: simulation
    include_dirs:
      - rtl
      - sim
    files:
      - sim/tb_mcu_ao.sv

//--- list.f
+incdir+rtl
+incdir+sim
rtl/mcu_ao_pkg.sv
rtl/ao_bus_demux.sv
rtl/gpio_bank.sv
rtl/power_seq.sv
rtl/power_ctrl.sv
rtl/mcu_ao_top.sv
sim/tb_mcu_ao.sv

//--- rtl/ao_bus_demux.sv
// always-on bus demux
// decodes obi requests to the gpio and power slaves, steers read data back

`timescale 1ns/100ps

`include "mcu_ao_consts.svh"

module ao_bus_demux
  import mcu_ao_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     bus_req_i,
  input  logic     bus_we_i,
  input  ao_word_t bus_addr_i,
  input  ao_word_t bus_wdata_i,
  output logic     bus_gnt_o,
  output logic     bus_rvalid_o,
  output ao_word_t bus_rdata_o,
  output logic     gpio_req_o,
  output logic     pwr_req_o,
  output logic     slv_we_o,
  output logic [7:0] slv_offs_o,
  output ao_word_t slv_wdata_o,
  input  ao_word_t gpio_rdata_i,
  input  ao_word_t pwr_rdata_i
);

  ao_slave_e sel;
  ao_slave_e sel_q;
  logic      rvalid_q;

  always_comb begin
    case (bus_addr_i[`AO_SEL_MSB:`AO_SEL_LSB])
      `AO_SEL_GPIO: sel = SLV_GPIO;
      `AO_SEL_PWR:  sel = SLV_PWR;
      default:      sel = SLV_NONE;
    endcase
  end

  // slaves never stall
  assign bus_gnt_o   = bus_req_i;
  assign gpio_req_o  = bus_req_i && (sel == SLV_GPIO);
  assign pwr_req_o   = bus_req_i && (sel == SLV_PWR);
  assign slv_we_o    = bus_we_i;
  assign slv_offs_o  = bus_addr_i[`AO_SEL_LSB-1:0];
  assign slv_wdata_o = bus_wdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      sel_q    <= SLV_NONE;
    end else begin
      rvalid_q <= bus_req_i;
      if (bus_req_i) sel_q <= sel;
    end
  end

  assign bus_rvalid_o = rvalid_q;

  // unmapped reads return zero
  always_comb begin
    case (sel_q)
      SLV_GPIO: bus_rdata_o = gpio_rdata_i;
      SLV_PWR:  bus_rdata_o = pwr_rdata_i;
      default:  bus_rdata_o = '0;
    endcase
  end

  a_gnt_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_gnt_o |-> bus_req_i && !(gpio_req_o && pwr_req_o))
    else $error("grant without request or with two slaves selected");

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_gnt_o |=> bus_rvalid_o)
    else $error("rvalid missing one cycle after grant");

endmodule

//--- rtl/gpio_bank.sv
// always-on gpio bank
// output and enable registers, synchronized inputs, rising-edge interrupts

`timescale 1ns/100ps

`include "mcu_ao_consts.svh"

module gpio_bank
  import mcu_ao_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [7:0]            offs_i,
  input  ao_word_t              wdata_i,
  output ao_word_t              rdata_o,
  input  logic [`AO_GPIO_N-1:0] gpio_i,
  output logic [`AO_GPIO_N-1:0] gpio_o,
  output logic [`AO_GPIO_N-1:0] gpio_oe_o,
  output logic                  irq_o
);

  logic [`AO_GPIO_N-1:0] out_q, oe_q, ien_q, status_q;
  logic [`AO_GPIO_N-1:0] sync1_q, sync2_q, prev_q;
  logic [`AO_GPIO_N-1:0] rise, clr;
  logic                  wr;
  ao_word_t              rdata_q;

  assign wr   = req_i && we_i;
  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr && offs_i == `GPIO_INTR_STATUS) ? wdata_i : '0;

  // two flop synchronizer plus one stage of history for edges
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      ien_q    <= '0;
      status_q <= '0;
    end else begin
      if (wr && offs_i == `GPIO_OUT) out_q <= wdata_i;
      if (wr && offs_i == `GPIO_OE) oe_q <= wdata_i;
      if (wr && offs_i == `GPIO_INTR_EN) ien_q <= wdata_i;
      // a new edge beats a clear of the same bit
      status_q <= (status_q & ~clr) | (rise & ien_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offs_i)
        `GPIO_OUT:         rdata_q <= out_q;
        `GPIO_OE:          rdata_q <= oe_q;
        `GPIO_IN:          rdata_q <= sync2_q;
        `GPIO_INTR_EN:     rdata_q <= ien_q;
        `GPIO_INTR_STATUS: rdata_q <= status_q;
        default:           rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o   = rdata_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |status_q;

  a_irq_from_edge: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(irq_o) |-> $past(|(rise & ien_q)))
    else $error("irq rose without an enabled input edge");

  a_irq_clear_by_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(irq_o) |-> $past(wr && offs_i == `GPIO_INTR_STATUS))
    else $error("irq dropped without a status clear");

endmodule

//--- rtl/mcu_ao_consts.svh
// always-on block constants
// widths, domain count, slave select field and register offsets

`ifndef MCU_AO_CONSTS_SVH
`define MCU_AO_CONSTS_SVH

`define AO_DATA_W        32
`define AO_GPIO_N        32
// domain 0 is the cpu, domain 1 the peripherals
`define AO_NUM_DOMAINS   2

`define AO_SEL_LSB       8
`define AO_SEL_MSB       11
`define AO_SEL_GPIO      4'd0
`define AO_SEL_PWR       4'd1

`define GPIO_OUT         8'h00
`define GPIO_OE          8'h04
`define GPIO_IN          8'h08
`define GPIO_INTR_EN     8'h0C
`define GPIO_INTR_STATUS 8'h10

`define PWR_OFF_REQ      8'h00
`define PWR_ON_REQ       8'h04
`define PWR_WAKE_EN      8'h08
`define PWR_STATUS       8'h0C

`endif

//--- rtl/mcu_ao_pkg.sv
// always-on block types
// bus word, slave select and power sequencer state

`include "mcu_ao_consts.svh"

package mcu_ao_pkg;

  typedef logic [`AO_DATA_W-1:0] ao_word_t;

  typedef enum logic [1:0] {
    SLV_GPIO = 2'd0,
    SLV_PWR  = 2'd1,
    SLV_NONE = 2'd2
  } ao_slave_e;

  // down order runs rst, iso, switch; up order is the reverse
  typedef enum logic [2:0] {
    PWR_ON          = 3'd0,
    PWR_RST_ASSERT  = 3'd1,
    PWR_ISO_ASSERT  = 3'd2,
    PWR_SWITCH_OFF  = 3'd3,
    PWR_OFF         = 3'd4,
    PWR_SWITCH_ON   = 3'd5,
    PWR_ISO_RELEASE = 3'd6,
    PWR_RST_RELEASE = 3'd7
  } pwr_state_e;

endpackage

//--- rtl/mcu_ao_top.sv
// always-on mcu corner
// obi slave port with gpio bank and power controller behind it

`timescale 1ns/100ps

`include "mcu_ao_consts.svh"

module mcu_ao_top
  import mcu_ao_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       bus_req_i,
  input  logic                       bus_we_i,
  input  ao_word_t                   bus_addr_i,
  input  ao_word_t                   bus_wdata_i,
  output logic                       bus_gnt_o,
  output logic                       bus_rvalid_o,
  output ao_word_t                   bus_rdata_o,
  input  logic [`AO_GPIO_N-1:0]      gpio_i,
  output logic [`AO_GPIO_N-1:0]      gpio_o,
  output logic [`AO_GPIO_N-1:0]      gpio_oe_o,
  output logic                       gpio_irq_o,
  input  logic [`AO_NUM_DOMAINS-1:0] pwr_switch_ack_ni,
  output logic [`AO_NUM_DOMAINS-1:0] pwr_switch_no,
  output logic [`AO_NUM_DOMAINS-1:0] pwr_iso_no,
  output logic [`AO_NUM_DOMAINS-1:0] pwr_rst_no
);

  logic       gpio_req, pwr_req, slv_we;
  logic [7:0] slv_offs;
  ao_word_t   slv_wdata, gpio_rdata, pwr_rdata;

  ao_bus_demux ao_bus_demux_i (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_we_i,
    .bus_addr_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .gpio_req_o  (gpio_req),
    .pwr_req_o   (pwr_req),
    .slv_we_o    (slv_we),
    .slv_offs_o  (slv_offs),
    .slv_wdata_o (slv_wdata),
    .gpio_rdata_i(gpio_rdata),
    .pwr_rdata_i (pwr_rdata)
  );

  gpio_bank gpio_bank_i (
    .clk_i,
    .rst_n_i,
    .req_i    (gpio_req),
    .we_i     (slv_we),
    .offs_i   (slv_offs),
    .wdata_i  (slv_wdata),
    .rdata_o  (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .irq_o    (gpio_irq_o)
  );

  // gpio interrupt doubles as the wake source
  power_ctrl power_ctrl_i (
    .clk_i,
    .rst_n_i,
    .req_i        (pwr_req),
    .we_i         (slv_we),
    .offs_i       (slv_offs),
    .wdata_i      (slv_wdata),
    .rdata_o      (pwr_rdata),
    .wake_i       (gpio_irq_o),
    .switch_ack_ni(pwr_switch_ack_ni),
    .switch_no    (pwr_switch_no),
    .iso_no       (pwr_iso_no),
    .rst_no       (pwr_rst_no)
  );

endmodule

//--- rtl/power_ctrl.sv
// power controller
// off/on request and wake registers driving one sequencer per domain

`timescale 1ns/100ps

`include "mcu_ao_consts.svh"

module power_ctrl
  import mcu_ao_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [7:0]                 offs_i,
  input  ao_word_t                   wdata_i,
  output ao_word_t                   rdata_o,
  input  logic                       wake_i,
  input  logic [`AO_NUM_DOMAINS-1:0] switch_ack_ni,
  output logic [`AO_NUM_DOMAINS-1:0] switch_no,
  output logic [`AO_NUM_DOMAINS-1:0] iso_no,
  output logic [`AO_NUM_DOMAINS-1:0] rst_no
);

  logic                       wr;
  logic [`AO_NUM_DOMAINS-1:0] off_pulse, on_pulse, wake_en_q, status;
  pwr_state_e                 state [`AO_NUM_DOMAINS];
  ao_word_t                   rdata_q;

  assign wr = req_i && we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wake_en_q <= '0;
    end else if (wr && offs_i == `PWR_WAKE_EN) begin
      wake_en_q <= wdata_i[`AO_NUM_DOMAINS-1:0];
    end
  end

  for (genvar d = 0; d < `AO_NUM_DOMAINS; d++) begin : g_dom
    assign off_pulse[d] = wr && offs_i == `PWR_OFF_REQ && wdata_i[d];
    // pending gpio interrupt brings a sleeping domain back
    assign on_pulse[d]  = (wr && offs_i == `PWR_ON_REQ && wdata_i[d]) ||
                          (wake_en_q[d] && wake_i && state[d] == PWR_OFF);
    assign status[d]    = state[d] inside {PWR_RST_RELEASE, PWR_ON};

    power_seq power_seq_i (
      .clk_i,
      .rst_n_i,
      .off_req_i    (off_pulse[d]),
      .on_req_i     (on_pulse[d]),
      .switch_ack_ni(switch_ack_ni[d]),
      .switch_no    (switch_no[d]),
      .iso_no       (iso_no[d]),
      .rst_no       (rst_no[d]),
      .state_o      (state[d])
    );
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (offs_i)
        `PWR_WAKE_EN: rdata_q <= {{(`AO_DATA_W-`AO_NUM_DOMAINS){1'b0}}, wake_en_q};
        `PWR_STATUS:  rdata_q <= {{(`AO_DATA_W-`AO_NUM_DOMAINS){1'b0}}, status};
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- rtl/power_seq.sv
// power domain sequencer
// orders reset, isolation and power switch on the way down and back up

`timescale 1ns/100ps

module power_seq
  import mcu_ao_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       off_req_i,
  input  logic       on_req_i,
  input  logic       switch_ack_ni,
  output logic       switch_no,
  output logic       iso_no,
  output logic       rst_no,
  output pwr_state_e state_o
);

  pwr_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      PWR_ON:          if (off_req_i) state_d = PWR_RST_ASSERT;
      PWR_RST_ASSERT:  state_d = PWR_ISO_ASSERT;
      PWR_ISO_ASSERT:  state_d = PWR_SWITCH_OFF;
      // switch latency varies, ack marks the end
      PWR_SWITCH_OFF:  if (switch_ack_ni) state_d = PWR_OFF;
      PWR_OFF:         if (on_req_i) state_d = PWR_SWITCH_ON;
      PWR_SWITCH_ON:   if (!switch_ack_ni) state_d = PWR_ISO_RELEASE;
      PWR_ISO_RELEASE: state_d = PWR_RST_RELEASE;
      PWR_RST_RELEASE: state_d = PWR_ON;
      default:         state_d = PWR_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= PWR_ON;
    end else begin
      state_q <= state_d;
    end
  end

  assign switch_no = !(state_q inside {PWR_SWITCH_OFF, PWR_OFF});
  assign iso_no    = state_q inside {PWR_ON, PWR_RST_ASSERT, PWR_ISO_RELEASE,
                                     PWR_RST_RELEASE};
  assign rst_no    = state_q inside {PWR_ON, PWR_RST_RELEASE};
  assign state_o   = state_q;

  // isolation lifts only once the switch has been closed a full cycle
  a_iso_after_switch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(iso_no) |-> switch_no && $past(switch_no))
    else $error("isolation released while switch off");

  a_rst_after_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(rst_no) |-> iso_no && $past(iso_no))
    else $error("reset released while isolation active");

endmodule

//--- sim/tb_mcu_ao_tasks.svh
// testbench helpers for the always-on block
// bus accesses, value checks and the external power switch model

task automatic report_failure(input string msg);
  $display("%s", msg);
  $display("TESTS FAILED");
  $fatal(1, "stopping at first error");
endtask

task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
  if (act !== exp) begin
    report_failure($sformatf("ERR %s actual 0x%h expected 0x%h", name, act, exp));
  end
endtask

function automatic ao_word_t reg_addr(input logic [3:0] sel, input logic [7:0] offs);
  return {20'h0, sel, offs};
endfunction

// one granted request with rvalid checked one cycle later
task automatic bus_access(input logic we, input ao_word_t addr, input ao_word_t wdata,
                          output ao_word_t rdata);
  @(posedge clk_i);
  bus_req_i   <= 1'b1;
  bus_we_i    <= we;
  bus_addr_i  <= addr;
  bus_wdata_i <= wdata;
  @(negedge clk_i);
  check_value("bus_gnt_o", bus_gnt_o, 1'b1);
  check_value("bus_rvalid_o", bus_rvalid_o, 1'b0);
  @(posedge clk_i);
  bus_req_i <= 1'b0;
  bus_we_i  <= 1'b0;
  @(negedge clk_i);
  check_value("bus_rvalid_o", bus_rvalid_o, 1'b1);
  rdata = bus_rdata_o;
endtask

task automatic bus_write(input ao_word_t addr, input ao_word_t wdata);
  ao_word_t unused;
  bus_access(1'b1, addr, wdata, unused);
endtask

task automatic read_check(input string name, input ao_word_t addr, input ao_word_t exp);
  ao_word_t data;
  bus_access(1'b0, addr, '0, data);
  check_value(name, data, exp);
endtask

// switch acknowledge follows the switch after 1 to 8 cycles
task automatic switch_model(input int d);
  logic level;
  int   lat;
  level = 1'b1;
  forever begin
    @(negedge clk_i);
    if (pwr_switch_no[d] !== level) begin
      level = pwr_switch_no[d];
      lat   = $urandom_range(8, 1);
      repeat (lat) @(posedge clk_i);
      pwr_switch_ack_ni[d] <= ~level;
    end
  end
endtask

// sequence is done two cycles after the acknowledge settles
task automatic wait_power_done(input int d);
  while (pwr_switch_ack_ni[d] !== !model_on[d]) @(posedge clk_i);
  repeat (2) @(posedge clk_i);
endtask

task automatic power_request(input int d, input logic off);
  bus_write(reg_addr(`AO_SEL_PWR, off ? `PWR_OFF_REQ : `PWR_ON_REQ), 32'(1) << d);
  // requests to a domain already there change nothing
  model_on[d] = !off;
  wait_power_done(d);
  read_check("bus_rdata_o pwr_status", reg_addr(`AO_SEL_PWR, `PWR_STATUS), 32'(model_on));
  check_value("pwr_switch_no", pwr_switch_no[d], model_on[d]);
  check_value("pwr_iso_no", pwr_iso_no[d], model_on[d]);
  check_value("pwr_rst_no", pwr_rst_no[d], model_on[d]);
endtask

//--- sim/tb_mcu_ao.sv
// testbench for the always-on mcu corner
// random bus traffic, gpio edges and power sequences against a register model

`timescale 1ns/100ps

`include "mcu_ao_consts.svh"

module tb_mcu_ao
  import mcu_ao_pkg::*;
();

  localparam int N_GPIO_OPS = 200;
  localparam int N_INPUT    = 30;
  localparam int N_PWR      = 12;
  localparam int N_UNMAP    = 20;
  localparam int BUS_OPS    = N_GPIO_OPS + 3 * N_INPUT + 2 * N_PWR + 2 * N_UNMAP + 20;
  localparam int PWR_TESTS  = N_PWR + 4;
  localparam int TIMEOUT_CYCLES = BUS_OPS * 20 + PWR_TESTS * 40;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic                       bus_req_i, bus_we_i;
  ao_word_t                   bus_addr_i, bus_wdata_i;
  logic                       bus_gnt_o, bus_rvalid_o;
  ao_word_t                   bus_rdata_o;
  logic [`AO_GPIO_N-1:0]      gpio_i, gpio_o, gpio_oe_o;
  logic                       gpio_irq_o;
  logic [`AO_NUM_DOMAINS-1:0] pwr_switch_ack_ni, pwr_switch_no, pwr_iso_no, pwr_rst_no;
  logic [`AO_NUM_DOMAINS-1:0] prev_switch, prev_iso, prev_rst;

  // register model for out, oe and intr_en
  logic [31:0]                model_reg [3];
  logic [31:0]                model_in, model_status;
  logic [`AO_NUM_DOMAINS-1:0] model_on, model_wake;

  `include "tb_mcu_ao_tasks.svh"

  mcu_ao_top uut (.*);

  always #50 clk_i = ~clk_i;

  // power order monitor
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int d = 0; d < `AO_NUM_DOMAINS; d++) begin
        if (prev_iso[d] && !pwr_iso_no[d] && prev_rst[d])
          report_failure($sformatf("domain %0d isolated before reset was asserted", d));
        if (prev_switch[d] && !pwr_switch_no[d] && prev_iso[d])
          report_failure($sformatf("domain %0d switch opened before isolation", d));
        if (!prev_iso[d] && pwr_iso_no[d] && !prev_switch[d])
          report_failure($sformatf("domain %0d isolation released before switch closed", d));
        if (!prev_rst[d] && pwr_rst_no[d] && !prev_iso[d])
          report_failure($sformatf("domain %0d reset released while isolated", d));
        if (pwr_iso_no[d] && pwr_switch_ack_ni[d])
          report_failure($sformatf("domain %0d isolation released before power ack", d));
      end
    end
    prev_switch <= pwr_switch_no;
    prev_iso    <= pwr_iso_no;
    prev_rst    <= pwr_rst_no;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    report_failure("timeout, the test sequence did not finish in time");
  end

  initial begin : main
    ao_word_t    val;
    ao_word_t    mask;
    int          r;
    logic [7:0]  offs;
    rst_n_i           = 1'b0;
    bus_req_i         = 1'b0;
    bus_we_i          = 1'b0;
    bus_addr_i        = '0;
    bus_wdata_i       = '0;
    gpio_i            = '0;
    pwr_switch_ack_ni = '0;
    model_reg         = '{default: '0};
    model_in          = '0;
    model_status      = '0;
    model_on          = '1;
    model_wake        = '0;
    void'($urandom(32'hb201_58fc));
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    fork
      switch_model(0);
      switch_model(1);
    join_none

    // reset values
    @(negedge clk_i);
    check_value("gpio_o", gpio_o, '0);
    check_value("gpio_oe_o", gpio_oe_o, '0);
    check_value("gpio_irq_o", gpio_irq_o, 1'b0);
    check_value("pwr_switch_no", pwr_switch_no, 2'b11);
    check_value("pwr_iso_no", pwr_iso_no, 2'b11);
    check_value("pwr_rst_no", pwr_rst_no, 2'b11);
    read_check("bus_rdata_o pwr_status", reg_addr(`AO_SEL_PWR, `PWR_STATUS), 32'h3);

    // gpio registers and pads
    for (int k = 0; k < N_GPIO_OPS; k++) begin
      r    = $urandom_range(2, 0);
      offs = (r == 2) ? `GPIO_INTR_EN : 8'(r * 4);
      if ($urandom_range(1, 0) == 1) begin
        val = $urandom;
        bus_write(reg_addr(`AO_SEL_GPIO, offs), val);
        model_reg[r] = val;
      end else begin
        read_check($sformatf("bus_rdata_o gpio 0x%h", offs), reg_addr(`AO_SEL_GPIO, offs),
                   model_reg[r]);
      end
      check_value("gpio_o", gpio_o, model_reg[0]);
      check_value("gpio_oe_o", gpio_oe_o, model_reg[1]);
    end

    // input capture and edge interrupts
    for (int k = 0; k < N_INPUT; k++) begin
      val = $urandom;
      @(posedge clk_i);
      gpio_i <= val;
      model_status = model_status | (val & ~model_in & model_reg[2]);
      model_in     = val;
      repeat (4) @(posedge clk_i);
      read_check("bus_rdata_o gpio_in", reg_addr(`AO_SEL_GPIO, `GPIO_IN), model_in);
      read_check("bus_rdata_o gpio_status", reg_addr(`AO_SEL_GPIO, `GPIO_INTR_STATUS),
                 model_status);
      check_value("gpio_irq_o", gpio_irq_o, |model_status);
      if ($urandom_range(1, 0) == 1) begin
        mask = $urandom;
        bus_write(reg_addr(`AO_SEL_GPIO, `GPIO_INTR_STATUS), mask);
        model_status = model_status & ~mask;
        check_value("gpio_irq_o", gpio_irq_o, |model_status);
      end
    end

    // power sequencing by register
    for (int k = 0; k < N_PWR; k++) begin
      power_request($urandom_range(1, 0), 1'($urandom_range(1, 0)));
    end

    // gpio wake of domain 0 while domain 1 without a wake bit stays off
    power_request(0, 1'b1);
    power_request(1, 1'b1);
    bus_write(reg_addr(`AO_SEL_GPIO, `GPIO_INTR_EN), 32'h1);
    model_reg[2] = 32'h1;
    @(posedge clk_i);
    gpio_i <= '0;
    model_in = '0;
    repeat (4) @(posedge clk_i);
    bus_write(reg_addr(`AO_SEL_GPIO, `GPIO_INTR_STATUS), '1);
    model_status = '0;
    bus_write(reg_addr(`AO_SEL_PWR, `PWR_WAKE_EN), 32'h1);
    model_wake = 2'b01;
    read_check("bus_rdata_o pwr_wake_en", reg_addr(`AO_SEL_PWR, `PWR_WAKE_EN), 32'(model_wake));
    check_value("gpio_irq_o", gpio_irq_o, 1'b0);
    @(posedge clk_i);
    gpio_i <= 32'h1;
    model_in     = 32'h1;
    model_status = 32'h1;
    model_on[0]  = 1'b1;
    wait_power_done(0);
    read_check("bus_rdata_o pwr_status", reg_addr(`AO_SEL_PWR, `PWR_STATUS), 32'(model_on));
    check_value("gpio_irq_o", gpio_irq_o, 1'b1);
    check_value("pwr_switch_no", pwr_switch_no, model_on);
    bus_write(reg_addr(`AO_SEL_GPIO, `GPIO_INTR_STATUS), '1);
    model_status = '0;

    // unmapped selects read zero and ignore writes
    for (int k = 0; k < N_UNMAP; k++) begin
      offs = 8'($urandom_range(4, 0) * 4);
      val  = reg_addr(4'($urandom_range(15, 2)), offs);
      read_check("bus_rdata_o unmapped", val, '0);
      bus_write(val, $urandom);
    end
    for (int k = 0; k < 3; k++) begin
      offs = (k == 2) ? `GPIO_INTR_EN : 8'(k * 4);
      read_check($sformatf("bus_rdata_o gpio 0x%h", offs), reg_addr(`AO_SEL_GPIO, offs),
                 model_reg[k]);
    end
    read_check("bus_rdata_o gpio_status", reg_addr(`AO_SEL_GPIO, `GPIO_INTR_STATUS),
               model_status);
    read_check("bus_rdata_o pwr_wake_en", reg_addr(`AO_SEL_PWR, `PWR_WAKE_EN), 32'(model_wake));
    read_check("bus_rdata_o pwr_status", reg_addr(`AO_SEL_PWR, `PWR_STATUS), 32'(model_on));
    check_value("gpio_o", gpio_o, model_reg[0]);
    check_value("gpio_oe_o", gpio_oe_o, model_reg[1]);

    $display("TESTS PASSED");
    $finish;
  end

endmodule
